// File: Makefile
# Verilator simulation of the AXI4-Lite IO bridge

VERILATOR ?= verilator
TOP       ?= axil_io_bridge_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/axil_io_bridge_assertions.sv
//##########################################################################
// Protocol checks on the AXI4-Lite decode stage
//##########################################################################
`timescale 1ns/10ps

module axil_io_bridge_assertions
  import io_bridge_pkg::*;
(
  input logic                          clk_i,
  input logic                          reset_i,
  input logic [2:0]                    s_axil_awprot_i,
  input logic                          s_axil_awvalid_i,
  input logic [axil_strb_width_lp-1:0] s_axil_wstrb_i,
  input logic                          s_axil_wvalid_i,
  input logic                          fwd_header_v_o,
  input logic                          fwd_header_ready_i,
  input logic [axil_addr_width_lp-1:0] fwd_addr_o,
  input logic                          fwd_data_v_o,
  input logic                          fwd_data_ready_i,
  input logic [io_data_width_lp-1:0]   fwd_data_o
);

  prot_zero: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_awvalid_i |-> s_axil_awprot_i == 3'b000)
    else $error("awprot not zero");

  strb_legal: assert property (@(posedge clk_i) disable iff (reset_i)
    s_axil_wvalid_i |-> (s_axil_wstrb_i inside {4'h1, 4'h3, 4'hf}))
    else $error("illegal write strobe");

  // Stalled handshakes keep their payload
  header_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_header_v_o && !fwd_header_ready_i |=> fwd_header_v_o && $stable(fwd_addr_o))
    else $error("header changed while stalled");

  data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    fwd_data_v_o && !fwd_data_ready_i |=> fwd_data_v_o && $stable(fwd_data_o))
    else $error("data beat changed while stalled");

endmodule

bind axil_to_burst axil_io_bridge_assertions checks (.*);

// File: dv/axil_io_bridge_tb.sv
//##########################################################################
// Directed testbench for the AXI4-Lite IO bridge with a byte window model
//##########################################################################
`timescale 1ns/10ps

module axil_io_bridge_tb;
  import io_bridge_pkg::*;

  // Reset 1, word 8, sized 11, priority 2, back-pressure 20, random 100
  localparam int num_ops_lp = 142;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  logic [31:0] s_axil_awaddr_i = '0, s_axil_araddr_i = '0, s_axil_wdata_i = '0;
  logic [2:0] s_axil_awprot_i = '0, s_axil_arprot_i = '0;
  logic [3:0] s_axil_wstrb_i = '0;
  logic s_axil_awvalid_i = 0, s_axil_wvalid_i = 0, s_axil_arvalid_i = 0;
  logic s_axil_bready_i = 0, s_axil_rready_i = 0;
  logic s_axil_awready_o, s_axil_wready_o, s_axil_arready_o;
  logic s_axil_bvalid_o, s_axil_rvalid_o;
  logic [31:0] s_axil_rdata_o;
  axi_resp_e s_axil_bresp_o, s_axil_rresp_o;

  logic [7:0] model_mem [64];
  logic [31:0] lfsr_r = 32'h7f8a;
  int checks = 0;
  int errors = 0;

  axil_io_bridge UUT (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_r[31] ^ lfsr_r[21] ^ lfsr_r[1] ^ lfsr_r[0];
      lfsr_r = {lfsr_r[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Window model, low bytes of the beat land at addr and wrap
  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) w[8*i +: 8] = model_mem[(addr + i) % 64];
    return w;
  endfunction

  task automatic check_data(input logic [31:0] act, exp_v, input string msg);
    checks++;
    if (act !== exp_v) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, msg, act, exp_v);
    end
  endtask

  task automatic check_resp(input axi_resp_e act, exp_v, input string msg);
    checks++;
    if (act !== exp_v) begin
      errors++;
      $display("FAILED at %0t: %s, got %s expected %s", $time, msg, act.name(), exp_v.name());
    end
  endtask

  // Waits for b or r, holds ready low for stall cycles, then accepts
  task automatic collect_resp(input bit is_read, input int stall, input logic [31:0] exp_v);
    logic [31:0] held;
    do @(negedge clk_i); while (!(is_read ? s_axil_rvalid_o : s_axil_bvalid_o));
    held = s_axil_rdata_o;
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_i);
      check_data({31'b0, is_read ? s_axil_rvalid_o : s_axil_bvalid_o}, 1, "valid dropped");
      if (is_read) check_data(s_axil_rdata_o, held, "rdata moved under stall");
    end
    @(posedge clk_i);
    #2;
    if (is_read) s_axil_rready_i = 1'b1;
    else s_axil_bready_i = 1'b1;
    @(negedge clk_i);
    if (is_read) begin
      check_data(s_axil_rdata_o, exp_v, "read data");
      check_resp(s_axil_rresp_o, e_axi_resp_okay, "rresp");
    end else begin
      check_resp(s_axil_bresp_o, e_axi_resp_okay, "bresp");
    end
    @(posedge clk_i);
    #2;
    s_axil_rready_i = 1'b0;
    s_axil_bready_i = 1'b0;
    @(negedge clk_i);
    check_data({30'b0, s_axil_bvalid_o, s_axil_rvalid_o}, 0, "duplicate response");
    @(posedge clk_i);
    #2;
  endtask

  task automatic axil_write(input logic [31:0] addr, data, input logic [3:0] strb,
                            input int stall);
    bit aw_done, w_done, aw_fire, w_fire;
    int nbytes;
    aw_done = 0;
    w_done = 0;
    s_axil_awaddr_i = addr;
    s_axil_wdata_i = data;
    s_axil_wstrb_i = strb;
    s_axil_awvalid_i = 1'b1;
    s_axil_wvalid_i = 1'b1;
    while (!(aw_done && w_done)) begin
      @(negedge clk_i);
      aw_fire = s_axil_awvalid_i && s_axil_awready_o;
      w_fire = s_axil_wvalid_i && s_axil_wready_o;
      @(posedge clk_i);
      #2;
      if (aw_fire) begin
        s_axil_awvalid_i = 1'b0;
        aw_done = 1;
      end
      if (w_fire) begin
        s_axil_wvalid_i = 1'b0;
        w_done = 1;
      end
    end
    nbytes = (strb == 4'h1) ? 1 : (strb == 4'h3) ? 2 : 4;
    for (int i = 0; i < nbytes; i++) model_mem[(addr + i) % 64] = data[8*i +: 8];
    collect_resp(0, stall, '0);
  endtask

  task automatic axil_read(input logic [31:0] addr, input int stall);
    bit ar_fire;
    s_axil_araddr_i = addr;
    s_axil_arvalid_i = 1'b1;
    do begin
      @(negedge clk_i);
      ar_fire = s_axil_arready_o;
      @(posedge clk_i);
      #2;
    end while (!ar_fire);
    s_axil_arvalid_i = 1'b0;
    collect_resp(1, stall, model_read(addr));
  endtask

  task automatic reset_test();
    check_data({27'b0, s_axil_bvalid_o, s_axil_rvalid_o, s_axil_awready_o,
                s_axil_wready_o, s_axil_arready_o}, 0, "outputs after reset");
    axil_read(32'h24, 0);
    $display("reset test done, %0d errors so far", errors);
  endtask

  task automatic word_test();
    for (int i = 0; i < 4; i++) axil_write(32'(i * 12), 32'hc0de_0000 + i, 4'hf, 0);
    for (int i = 0; i < 4; i++) axil_read(32'(i * 12), 0);
    $display("word access test done, %0d errors so far", errors);
  endtask

  task automatic sized_test();
    axil_write(32'h8, 32'h1122_3344, 4'hf, 0);
    axil_write(32'h9, 32'h0000_00aa, 4'h1, 0);
    axil_write(32'ha, 32'h0000_bbcc, 4'h3, 0);
    axil_read(32'h8, 0);
    axil_write(32'h3f, 32'h0000_5a6b, 4'h3, 0);
    axil_read(32'h3e, 0);
    axil_read(32'h0, 0);
    // 0x45 aliases onto byte 5
    axil_write(32'h45, 32'h0000_0077, 4'h1, 0);
    axil_read(32'h4, 0);
    axil_write(32'h3e, 32'hdead_beef, 4'hf, 0);
    axil_read(32'h3d, 0);
    $display("sized write test done, %0d errors so far", errors);
  endtask

  task automatic priority_test();
    bit aw_fire, w_fire, ar_fire;
    int cycle, b_cycle, r_cycle;
    logic [31:0] exp_v;
    cycle = 0;
    b_cycle = -1;
    r_cycle = -1;
    s_axil_awaddr_i = 32'h20;
    s_axil_araddr_i = 32'h20;
    s_axil_wdata_i = 32'h600d_f00d;
    s_axil_wstrb_i = 4'hf;
    for (int i = 0; i < 4; i++) model_mem[32 + i] = s_axil_wdata_i[8*i +: 8];
    exp_v = model_read(32'h20);
    {s_axil_awvalid_i, s_axil_wvalid_i, s_axil_arvalid_i} = 3'b111;
    {s_axil_bready_i, s_axil_rready_i} = 2'b11;
    while (b_cycle < 0 || r_cycle < 0) begin
      @(negedge clk_i);
      cycle++;
      aw_fire = s_axil_awvalid_i && s_axil_awready_o;
      w_fire = s_axil_wvalid_i && s_axil_wready_o;
      ar_fire = s_axil_arvalid_i && s_axil_arready_o;
      if (s_axil_bvalid_o) b_cycle = cycle;
      if (s_axil_rvalid_o) begin
        r_cycle = cycle;
        check_data(s_axil_rdata_o, exp_v, "read after write");
      end
      @(posedge clk_i);
      #2;
      if (aw_fire) s_axil_awvalid_i = 1'b0;
      if (w_fire) s_axil_wvalid_i = 1'b0;
      if (ar_fire) s_axil_arvalid_i = 1'b0;
    end
    {s_axil_bready_i, s_axil_rready_i} = 2'b00;
    check_data({31'b0, b_cycle < r_cycle}, 1, "b response after r response");
    $display("write priority test done, %0d errors so far", errors);
  endtask

  task automatic backpressure_test();
    logic [31:0] addr;
    for (int i = 0; i < 10; i++) begin
      addr = rand_bits(6);
      axil_write(addr, rand_bits(32), 4'hf, int'(rand_bits(3)));
      axil_read(addr, int'(rand_bits(3)));
    end
    $display("back-pressure test done, %0d errors so far", errors);
  endtask

  task automatic random_test();
    logic [3:0] strb;
    logic [1:0] pick;
    for (int i = 0; i < 100; i++) begin
      pick = rand_bits(2);
      strb = (pick == 2'd0) ? 4'h1 : (pick == 2'd1) ? 4'h3 : 4'hf;
      if (rand_bits(1)) axil_write(rand_bits(8), rand_bits(32), strb, 0);
      else axil_read(rand_bits(8), 0);
    end
    $display("random traffic test done, %0d errors so far", errors);
  endtask

  initial begin
    #(num_ops_lp * 200 * 40);
    $display("Timeout: the DUT stopped responding before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    for (int i = 0; i < 64; i++) model_mem[i] = 8'h00;
    repeat (4) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    reset_test();
    word_test();
    sized_test();
    priority_test();
    backpressure_test();
    random_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
source/io_bridge_pkg.sv
source/axil_to_burst.sv
source/io_reg_target.sv
source/burst_to_axil_resp.sv
source/axil_io_bridge.sv
dv/axil_io_bridge_assertions.sv
dv/axil_io_bridge_tb.sv

// File: source/axil_io_bridge.sv
//##########################################################################
// AXI4-Lite IO bridge top
// Decode, register target and response stages in series
//##########################################################################
`timescale 1ns/10ps

module axil_io_bridge
  import io_bridge_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  input  logic [axil_addr_width_lp-1:0] s_axil_awaddr_i,
  input  logic [2:0]                    s_axil_awprot_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,

  input  logic [axil_data_width_lp-1:0] s_axil_wdata_i,
  input  logic [axil_strb_width_lp-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,

  output axi_resp_e                     s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i,

  input  logic [axil_addr_width_lp-1:0] s_axil_araddr_i,
  input  logic [2:0]                    s_axil_arprot_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,

  output logic [axil_data_width_lp-1:0] s_axil_rdata_o,
  output axi_resp_e                     s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i
);

  // Forward path
  logic                          fwd_header_v, fwd_header_ready, fwd_has_data;
  bedrock_msg_e                  fwd_msg;
  bedrock_size_e                 fwd_size;
  logic [axil_addr_width_lp-1:0] fwd_addr;
  logic                          fwd_data_v, fwd_data_ready, fwd_last;
  logic [io_data_width_lp-1:0]   fwd_data;

  // Reverse path
  logic                          rev_header_v, rev_header_ready;
  bedrock_msg_e                  rev_msg;
  bedrock_size_e                 rev_size;
  logic                          rev_data_v, rev_data_ready;
  logic [io_data_width_lp-1:0]   rev_data;

  axil_to_burst decode (
    .clk_i, .reset_i,
    .s_axil_awaddr_i, .s_axil_awprot_i, .s_axil_awvalid_i, .s_axil_awready_o,
    .s_axil_wdata_i, .s_axil_wstrb_i, .s_axil_wvalid_i, .s_axil_wready_o,
    .s_axil_araddr_i, .s_axil_arprot_i, .s_axil_arvalid_i, .s_axil_arready_o,
    .fwd_header_v_o(fwd_header_v), .fwd_msg_o(fwd_msg), .fwd_size_o(fwd_size),
    .fwd_addr_o(fwd_addr), .fwd_has_data_o(fwd_has_data),
    .fwd_header_ready_i(fwd_header_ready),
    .fwd_data_v_o(fwd_data_v), .fwd_data_o(fwd_data), .fwd_last_o(fwd_last),
    .fwd_data_ready_i(fwd_data_ready)
  );

  io_reg_target execute (
    .clk_i, .reset_i,
    .fwd_header_v_i(fwd_header_v), .fwd_msg_i(fwd_msg), .fwd_size_i(fwd_size),
    .fwd_addr_i(fwd_addr), .fwd_has_data_i(fwd_has_data),
    .fwd_header_ready_o(fwd_header_ready),
    .fwd_data_v_i(fwd_data_v), .fwd_data_i(fwd_data), .fwd_last_i(fwd_last),
    .fwd_data_ready_o(fwd_data_ready),
    .rev_header_v_o(rev_header_v), .rev_msg_o(rev_msg), .rev_size_o(rev_size),
    .rev_header_ready_i(rev_header_ready),
    .rev_data_v_o(rev_data_v), .rev_data_o(rev_data), .rev_data_ready_i(rev_data_ready)
  );

  burst_to_axil_resp result (
    .clk_i, .reset_i,
    .rev_header_v_i(rev_header_v), .rev_msg_i(rev_msg), .rev_size_i(rev_size),
    .rev_header_ready_o(rev_header_ready),
    .rev_data_v_i(rev_data_v), .rev_data_i(rev_data), .rev_data_ready_o(rev_data_ready),
    .s_axil_rdata_o, .s_axil_rresp_o, .s_axil_rvalid_o, .s_axil_rready_i,
    .s_axil_bresp_o, .s_axil_bvalid_o, .s_axil_bready_i
  );

endmodule

// File: source/axil_to_burst.sv
//##########################################################################
// AXI4-Lite request decoder
// Serializes writes and reads into single-beat uncached burst commands
//##########################################################################
`timescale 1ns/10ps

module axil_to_burst
  import io_bridge_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  // AXI4-Lite write address
  input  logic [axil_addr_width_lp-1:0] s_axil_awaddr_i,
  input  logic [2:0]                    s_axil_awprot_i,
  input  logic                          s_axil_awvalid_i,
  output logic                          s_axil_awready_o,

  // AXI4-Lite write data
  input  logic [axil_data_width_lp-1:0] s_axil_wdata_i,
  input  logic [axil_strb_width_lp-1:0] s_axil_wstrb_i,
  input  logic                          s_axil_wvalid_i,
  output logic                          s_axil_wready_o,

  // AXI4-Lite read address
  input  logic [axil_addr_width_lp-1:0] s_axil_araddr_i,
  input  logic [2:0]                    s_axil_arprot_i,
  input  logic                          s_axil_arvalid_i,
  output logic                          s_axil_arready_o,

  // Forward header
  output logic                          fwd_header_v_o,
  output bedrock_msg_e                  fwd_msg_o,
  output bedrock_size_e                 fwd_size_o,
  output logic [axil_addr_width_lp-1:0] fwd_addr_o,
  output logic                          fwd_has_data_o,
  input  logic                          fwd_header_ready_i,

  // Forward data
  output logic                          fwd_data_v_o,
  output logic [io_data_width_lp-1:0]   fwd_data_o,
  output logic                          fwd_last_o,
  input  logic                          fwd_data_ready_i
);

  typedef enum logic [1:0] {
    e_idle,
    e_write_addr,
    e_write_data,
    e_read_addr
  } state_e;

  state_e state_r, state_n;
  bedrock_size_e wsize;

  // Strobe pattern gives the write size
  always_comb begin
    case (s_axil_wstrb_i)
      4'h1:    wsize = e_size_1;
      4'h3:    wsize = e_size_2;
      4'hf:    wsize = e_size_4;
      // illegal patterns fall back to a full word
      default: wsize = e_size_4;
    endcase
  end

  always_comb begin
    state_n = state_r;

    fwd_header_v_o = 1'b0;
    fwd_msg_o      = e_uc_rd;
    fwd_size_o     = e_size_4;
    fwd_addr_o     = '0;
    fwd_has_data_o = 1'b0;

    // Single beat bursts, data is just the AXI write data
    fwd_data_v_o = 1'b0;
    fwd_data_o   = s_axil_wdata_i;
    fwd_last_o   = 1'b1;

    s_axil_awready_o = 1'b0;
    s_axil_wready_o  = 1'b0;
    s_axil_arready_o = 1'b0;

    case (state_r)
      // Writes win over reads
      e_idle: begin
        if (s_axil_awvalid_i) begin
          state_n = e_write_addr;
        end else if (s_axil_arvalid_i) begin
          state_n = e_read_addr;
        end
      end

      e_write_addr: begin
        fwd_header_v_o   = s_axil_awvalid_i;
        fwd_msg_o        = e_uc_wr;
        fwd_size_o       = wsize;
        fwd_addr_o       = s_axil_awaddr_i;
        fwd_has_data_o   = 1'b1;
        s_axil_awready_o = fwd_header_ready_i;
        if (s_axil_awvalid_i && fwd_header_ready_i) begin
          state_n = e_write_data;
        end
      end

      e_write_data: begin
        fwd_data_v_o    = s_axil_wvalid_i;
        s_axil_wready_o = fwd_data_ready_i;
        if (s_axil_wvalid_i && fwd_data_ready_i) begin
          state_n = e_idle;
        end
      end

      // Reads always fetch the full bus width
      e_read_addr: begin
        fwd_header_v_o   = s_axil_arvalid_i;
        fwd_msg_o        = e_uc_rd;
        fwd_size_o       = e_size_4;
        fwd_addr_o       = s_axil_araddr_i;
        s_axil_arready_o = fwd_header_ready_i;
        if (s_axil_arvalid_i && fwd_header_ready_i) begin
          state_n = e_idle;
        end
      end

      default: state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
    end else begin
      state_r <= state_n;
    end
  end

endmodule

// File: source/burst_to_axil_resp.sv
//##########################################################################
// Burst response to AXI4-Lite converter
// Queues response headers and steers them to the r or b channel
//##########################################################################
`timescale 1ns/10ps

module burst_to_axil_resp
  import io_bridge_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  // Reverse header
  input  logic                          rev_header_v_i,
  input  bedrock_msg_e                  rev_msg_i,
  input  bedrock_size_e                 rev_size_i,
  output logic                          rev_header_ready_o,

  // Reverse data
  input  logic                          rev_data_v_i,
  input  logic [io_data_width_lp-1:0]   rev_data_i,
  output logic                          rev_data_ready_o,

  // AXI4-Lite responses
  output logic [axil_data_width_lp-1:0] s_axil_rdata_o,
  output axi_resp_e                     s_axil_rresp_o,
  output logic                          s_axil_rvalid_o,
  input  logic                          s_axil_rready_i,
  output axi_resp_e                     s_axil_bresp_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_bready_i
);

  // Two entry header queue, only the message type is kept
  bedrock_msg_e slot_r [2];
  logic         wptr_r;
  logic         rptr_r;
  logic [1:0]   count_r;

  logic         enq;
  logic         deq;
  logic         front_v;
  logic         front_rd;

  assign rev_header_ready_o = (count_r != 2'd2);
  assign enq      = rev_header_v_i & rev_header_ready_o;
  assign front_v  = (count_r != 2'd0);
  assign front_rd = front_v & (slot_r[rptr_r] == e_uc_rd);

  // Read beats need both the header and its data
  assign s_axil_rvalid_o  = front_rd & rev_data_v_i;
  assign s_axil_rdata_o   = rev_data_i;
  assign s_axil_rresp_o   = e_axi_resp_okay;
  assign rev_data_ready_o = front_rd & s_axil_rready_i;

  assign s_axil_bvalid_o = front_v & (slot_r[rptr_r] == e_uc_wr);
  assign s_axil_bresp_o  = e_axi_resp_okay;

  assign deq = (s_axil_rvalid_o & s_axil_rready_i) | (s_axil_bvalid_o & s_axil_bready_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      count_r <= 2'd0;
    end else begin
      if (enq) wptr_r <= ~wptr_r;
      if (deq) rptr_r <= ~rptr_r;
      count_r <= count_r + {1'b0, enq} - {1'b0, deq};
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      slot_r[wptr_r] <= rev_msg_i;
    end
  end

endmodule

// File: source/io_bridge_pkg.sv
//##########################################################################
// AXI4-Lite IO bridge shared definitions
// Bus widths, register window size, burst and AXI response encodings
//##########################################################################
package io_bridge_pkg;

  // AXI4-Lite bus geometry
  localparam int axil_data_width_lp = 32;
  localparam int axil_strb_width_lp = axil_data_width_lp / 8;
  localparam int axil_addr_width_lp = 32;

  // Burst data beat is as wide as the AXI data bus
  localparam int io_data_width_lp = axil_data_width_lp;

  // Register window, byte addressed
  localparam int reg_window_bytes_lp = 64;
  localparam int reg_addr_width_lp = $clog2(reg_window_bytes_lp);

  // Burst message types, only the uncached pair is used
  typedef enum logic [1:0] {
    e_uc_rd = 2'b00,
    e_uc_wr = 2'b01
  } bedrock_msg_e;

  // Access size, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } bedrock_size_e;

  // AXI response codes
  typedef enum logic [1:0] {
    e_axi_resp_okay   = 2'b00,
    e_axi_resp_exokay = 2'b01,
    e_axi_resp_slverr = 2'b10,
    e_axi_resp_decerr = 2'b11
  } axi_resp_e;

endpackage

// File: source/io_reg_target.sv
//##########################################################################
// IO register target
// Runs uncached burst reads and writes on a 64-byte register store
//##########################################################################
`timescale 1ns/10ps

module io_reg_target
  import io_bridge_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          reset_i,

  // Forward header
  input  logic                          fwd_header_v_i,
  input  bedrock_msg_e                  fwd_msg_i,
  input  bedrock_size_e                 fwd_size_i,
  input  logic [axil_addr_width_lp-1:0] fwd_addr_i,
  input  logic                          fwd_has_data_i,
  output logic                          fwd_header_ready_o,

  // Forward data
  input  logic                          fwd_data_v_i,
  input  logic [io_data_width_lp-1:0]   fwd_data_i,
  input  logic                          fwd_last_i,
  output logic                          fwd_data_ready_o,

  // Reverse header
  output logic                          rev_header_v_o,
  output bedrock_msg_e                  rev_msg_o,
  output bedrock_size_e                 rev_size_o,
  input  logic                          rev_header_ready_i,

  // Reverse data
  output logic                          rev_data_v_o,
  output logic [io_data_width_lp-1:0]   rev_data_o,
  input  logic                          rev_data_ready_i
);

  logic [7:0] store_r [reg_window_bytes_lp];

  // Write command waiting on its data beat
  logic                         wait_data_r;
  bedrock_size_e                cmd_size_r;
  logic [reg_addr_width_lp-1:0] cmd_addr_r;

  // Registered response
  logic                        rev_header_v_r;
  logic                        rev_data_v_r;
  bedrock_msg_e                rev_msg_r;
  bedrock_size_e               rev_size_r;
  logic [io_data_width_lp-1:0] rev_data_r;

  logic                        header_fire;
  logic                        data_fire;
  logic                        write_done;
  logic                        read_fire;
  logic [2:0]                  wr_bytes;
  logic [io_data_width_lp-1:0] rd_word;

  assign fwd_header_ready_o = ~(rev_header_v_r | rev_data_v_r) & ~wait_data_r;
  assign fwd_data_ready_o   = wait_data_r;

  assign header_fire = fwd_header_v_i & fwd_header_ready_o;
  assign data_fire   = fwd_data_v_i & fwd_data_ready_o;
  assign write_done  = data_fire & fwd_last_i;
  assign read_fire   = header_fire & ~fwd_has_data_i;

  // Read word, lowest address in the lowest byte, wraps in the window
  always_comb begin
    for (int i = 0; i < axil_strb_width_lp; i++) begin
      rd_word[8*i +: 8] = store_r[fwd_addr_i[reg_addr_width_lp-1:0] + reg_addr_width_lp'(i)];
    end
  end

  always_comb begin
    case (cmd_size_r)
      e_size_1: wr_bytes = 3'd1;
      e_size_2: wr_bytes = 3'd2;
      default:  wr_bytes = 3'd4;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < reg_window_bytes_lp; i++) begin
        store_r[i] <= '0;
      end
    end else if (data_fire) begin
      for (int i = 0; i < axil_strb_width_lp; i++) begin
        if (i < wr_bytes) begin
          store_r[cmd_addr_r + reg_addr_width_lp'(i)] <= fwd_data_i[8*i +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wait_data_r    <= 1'b0;
      rev_header_v_r <= 1'b0;
      rev_data_v_r   <= 1'b0;
    end else begin
      if (header_fire && fwd_has_data_i) begin
        wait_data_r <= 1'b1;
      end else if (write_done) begin
        wait_data_r <= 1'b0;
      end

      // New responses only start when none is pending
      if (read_fire) begin
        rev_header_v_r <= 1'b1;
        rev_data_v_r   <= 1'b1;
      end else if (write_done) begin
        rev_header_v_r <= 1'b1;
      end else begin
        if (rev_header_ready_i) rev_header_v_r <= 1'b0;
        if (rev_data_ready_i) rev_data_v_r <= 1'b0;
      end
    end
  end

  // Response type and size echo the command
  always_ff @(posedge clk_i) begin
    if (header_fire) begin
      cmd_size_r <= fwd_size_i;
      cmd_addr_r <= fwd_addr_i[reg_addr_width_lp-1:0];
      rev_msg_r  <= fwd_msg_i;
      rev_size_r <= fwd_size_i;
    end
    if (read_fire) begin
      rev_data_r <= rd_word;
    end
  end

  assign rev_header_v_o = rev_header_v_r;
  assign rev_msg_o      = rev_msg_r;
  assign rev_size_o     = rev_size_r;
  assign rev_data_v_o   = rev_data_v_r;
  assign rev_data_o     = rev_data_r;

endmodule
